/* hdl/host_wr_pkg.sv */
/*
 host write path package
 widths of the host write channel, user flag bit positions and DMA engine states
*/
package host_wr_pkg;

    // byte address toward host memory
    localparam int addr_w = 32;

    // one beat of write data
    localparam int data_w = 64;

    // one byteenable bit per data byte
    localparam int be_w = data_w / 8;

    // burstcount field, a burst carries at most 255 beats
    localparam int burst_w = 8;

    // out-of-band user field that travels with every write beat
    localparam int user_w = 2;

    // this user bit turns a one-beat write into an interrupt toward the host
    localparam int uflag_interrupt = 0;

    // this user bit marks a write fence ahead of the completion write
    localparam int uflag_fence = 1;

    // the engine walks idle, burst, then optionally fence and magic
    typedef enum logic [1:0] {
        eng_idle,
        eng_burst,
        eng_fence,
        eng_magic
    } eng_state_t;

endpackage

/* hdl/host_wr_if.sv */
/*
 Avalon-style write channel between the DMA engine, the mux and the host port
*/
`timescale 1ns/10ps

interface host_wr_if;

    logic [host_wr_pkg::addr_w-1:0]  address;
    logic [host_wr_pkg::data_w-1:0]  writedata;
    logic [host_wr_pkg::be_w-1:0]    byteenable;
    logic [host_wr_pkg::burst_w-1:0] burstcount;
    logic                            write;
    logic [host_wr_pkg::user_w-1:0]  user;
    // a beat moves on a cycle with write high and waitrequest low
    logic                            waitrequest;

    // the side that issues writes
    modport source (
        output address,
        output writedata,
        output byteenable,
        output burstcount,
        output write,
        output user,
        input  waitrequest
    );

    // the side that accepts writes and can stall them
    modport sink (
        input  address,
        input  writedata,
        input  byteenable,
        input  burstcount,
        input  write,
        input  user,
        output waitrequest
    );

endinterface

/* hdl/irq_line_latch.sv */
/*
 interrupt line latch
 captures a rising edge on one board interrupt line and keeps it pending until sent
*/
`timescale 1ns/10ps

module irq_line_latch (
    input  logic clk,
    input  logic rst_local,
    input  logic irq,
    input  logic clear,
    output logic pending
);

    logic irq_q;
    logic rise;

    // previous level of the line, used for edge detection
    always_ff @(posedge clk) begin
        if (rst_local) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= irq;
        end
    end

    // only a low to high change counts, a line that stays high raises no second request
    assign rise = irq && !irq_q;

    // a fresh edge in the same cycle as the clear must not be lost
    // so the set takes priority and the line stays pending
    always_ff @(posedge clk) begin
        if (rst_local) begin
            pending <= 1'b0;
        end else if (rise) begin
            pending <= 1'b1;
        end else if (clear) begin
            pending <= 1'b0;
        end
    end

endmodule

/* hdl/irq_select.sv */
/*
 interrupt selector
 picks the lowest pending line and clears it once its interrupt write has gone out
*/
`timescale 1ns/10ps

module irq_select #(
    parameter int NUM_IRQ = 4
) (
    input  logic               clk,
    input  logic               rst_local,
    input  logic [NUM_IRQ-1:0] pending,
    input  logic               irq_sent,
    output logic               irq_any,
    output logic [1:0]         irq_id,
    output logic [NUM_IRQ-1:0] clear
);

    assign irq_any = |pending;

    // scan from the top down so the lowest pending index is the one that sticks
    always_comb begin
        irq_id = '0;
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (pending[i]) begin
                irq_id = 2'(i);
            end
        end
    end

    // the clear hits exactly the line whose id went out on the host channel
    always_comb begin
        for (int i = 0; i < NUM_IRQ; i++) begin
            clear[i] = irq_sent && (irq_id == 2'(i));
        end
    end

    // the mux may only send an interrupt write while some line is pending
    a_sent_needs_pending: assert property (
        @(posedge clk) disable iff (rst_local)
        irq_sent |-> irq_any
    );

endmodule

/* hdl/dma_wr_engine.sv */
/*
 write DMA engine
 turns one descriptor into a burst of writes with an optional fence and magic write
*/
`timescale 1ns/10ps

module dma_wr_engine (
    input  logic                            clk,
    input  logic                            rst_local,
    input  logic                            desc_valid,
    input  logic [host_wr_pkg::addr_w-1:0]  desc_addr,
    input  logic [host_wr_pkg::burst_w-1:0] desc_beats,
    input  logic                            desc_fence,
    input  logic [host_wr_pkg::data_w-1:0]  desc_magic,
    output logic                            desc_busy,
    output logic                            fence_req,
    host_wr_if.source                       wr
);

    localparam int aw = host_wr_pkg::addr_w;
    localparam int dw = host_wr_pkg::data_w;
    localparam int bw = host_wr_pkg::burst_w;

    host_wr_pkg::eng_state_t state;

    logic [bw-1:0] beats_left;
    logic [aw-1:0] addr_q;
    logic [dw-1:0] data_q;
    logic [dw-1:0] magic_q;
    logic [bw-1:0] bcount_q;
    logic          fence_q;
    logic          xfer;

    // a beat leaves only when the mux does not hold us off
    assign xfer = wr.write && !wr.waitrequest;

    // descriptors are only taken in idle, a strobe while busy is dropped
    // a beat count of zero is not a legal burst and is not expected here
    always_ff @(posedge clk) begin
        if (rst_local) begin
            state      <= host_wr_pkg::eng_idle;
            beats_left <= '0;
        end else begin
            case (state)
                host_wr_pkg::eng_idle: begin
                    if (desc_valid) begin
                        state      <= host_wr_pkg::eng_burst;
                        beats_left <= desc_beats;
                    end
                end
                host_wr_pkg::eng_burst: begin
                    if (xfer) begin
                        beats_left <= beats_left - 1'b1;
                        // the last beat decides whether a completion write follows
                        if (beats_left == bw'(1)) begin
                            state <= fence_q ? host_wr_pkg::eng_fence : host_wr_pkg::eng_idle;
                        end
                    end
                end
                host_wr_pkg::eng_fence: begin
                    state <= host_wr_pkg::eng_magic;
                end
                host_wr_pkg::eng_magic: begin
                    if (xfer) begin
                        state <= host_wr_pkg::eng_idle;
                    end
                end
                default: begin
                    state <= host_wr_pkg::eng_idle;
                end
            endcase
        end
    end

    // payload registers follow the state machine and need no reset
    always_ff @(posedge clk) begin
        case (state)
            host_wr_pkg::eng_idle: begin
                if (desc_valid) begin
                    addr_q   <= desc_addr;
                    data_q   <= {{(dw - aw){1'b0}}, desc_addr};
                    bcount_q <= desc_beats;
                    fence_q  <= desc_fence;
                    magic_q  <= desc_magic;
                end
            end
            host_wr_pkg::eng_burst: begin
                // beat k carries the descriptor address plus k
                if (xfer) begin
                    data_q <= data_q + 1'b1;
                end
            end
            host_wr_pkg::eng_fence: begin
                // rearm the payload as a single beat holding the magic number
                data_q   <= magic_q;
                bcount_q <= bw'(1);
            end
            default: begin
            end
        endcase
    end

    assign desc_busy = (state != host_wr_pkg::eng_idle);

    // the mux turns this into a fence marker ahead of the magic write
    assign fence_req = (state == host_wr_pkg::eng_magic);

    // address and burstcount stay fixed for every beat of the burst
    assign wr.address    = addr_q;
    assign wr.writedata  = data_q;
    assign wr.byteenable = '1;
    assign wr.burstcount = bcount_q;
    assign wr.write      = (state == host_wr_pkg::eng_burst) ||
                           (state == host_wr_pkg::eng_magic);
    assign wr.user       = '0;

    // a stalled beat must come back unchanged on the next cycle
    a_hold_under_wait: assert property (
        @(posedge clk) disable iff (rst_local)
        (wr.write && wr.waitrequest) |=>
            (wr.write && $stable(wr.address) && $stable(wr.writedata) &&
             $stable(wr.burstcount) && $stable(fence_req))
    );

endmodule

/* hdl/host_wr_mux.sv */
/*
 host write channel mux
 merges DMA bursts, one-beat interrupt writes and fence markers onto the host port
*/
`timescale 1ns/10ps

module host_wr_mux #(
    parameter int NUM_IRQ = 4
) (
    input  logic       clk,
    input  logic       rst_local,
    host_wr_if.sink    dma,
    host_wr_if.source  host,
    input  logic       fence_req,
    input  logic       irq_any,
    input  logic [1:0] irq_id,
    output logic       irq_sent
);

    localparam int aw = host_wr_pkg::addr_w;
    localparam int bw = host_wr_pkg::burst_w;

    logic [bw-1:0] remaining;
    logic          hold_dma_q;
    logic          fence_sent_q;
    logic          fence_wait;
    logic          send_irq;
    logic          send_fence;
    logic          dma_xfer;

    // the engine wants a fence and the marker beat has not gone out yet
    assign fence_wait = fence_req && !fence_sent_q;

    // an interrupt write is only started when it transfers right away
    // it never splits a burst, never cuts in ahead of a stalled DMA beat
    // and never sits between the fence marker and its magic write
    assign send_irq = irq_any && (remaining == '0) && !host.waitrequest &&
                      !hold_dma_q && !fence_sent_q;

    // interrupts win over starting a fence
    assign send_fence = dma.write && fence_wait && !irq_any && !host.waitrequest;

    assign irq_sent = send_irq;

    // the DMA side is held while the host stalls, while an interrupt goes out
    // and for the whole time until the fence marker has been sent
    assign dma.waitrequest = host.waitrequest || send_irq || fence_wait;

    assign dma_xfer = dma.write && !dma.waitrequest;

    // count the beats still owed by the current burst
    // zero means no burst is in progress and the channel is free for an interrupt
    always_ff @(posedge clk) begin
        if (rst_local) begin
            remaining <= '0;
        end else if (dma_xfer) begin
            if (remaining == '0) begin
                remaining <= dma.burstcount - 1'b1;
            end else begin
                remaining <= remaining - 1'b1;
            end
        end
    end

    // only a passed DMA beat can be stalled, interrupts and markers go out unstalled
    // so this flag keeps the stalled DMA beat on the host lines until it transfers
    always_ff @(posedge clk) begin
        if (rst_local) begin
            hold_dma_q <= 1'b0;
        end else begin
            hold_dma_q <= host.write && host.waitrequest;
        end
    end

    // set by the marker beat, cleared when the unflagged magic write transfers
    always_ff @(posedge clk) begin
        if (rst_local) begin
            fence_sent_q <= 1'b0;
        end else if (send_fence) begin
            fence_sent_q <= 1'b1;
        end else if (dma_xfer && fence_req) begin
            fence_sent_q <= 1'b0;
        end
    end

    // the interrupt write carries its line id as address with zero data
    always_comb begin
        if (send_irq) begin
            host.address    = {{(aw - 2){1'b0}}, irq_id};
            host.writedata  = '0;
            host.byteenable = '1;
            host.burstcount = bw'(1);
        end else begin
            host.address    = dma.address;
            host.writedata  = dma.writedata;
            host.byteenable = dma.byteenable;
            host.burstcount = dma.burstcount;
        end
    end

    // while a fence is waiting the magic write is kept off the host until the marker
    assign host.write = send_irq || send_fence || (dma.write && !fence_wait);

    // the marker beat is the magic write itself with the fence flag added
    always_comb begin
        host.user = dma.user;
        if (send_irq) begin
            host.user = '0;
            host.user[host_wr_pkg::uflag_interrupt] = 1'b1;
        end else if (send_fence) begin
            host.user = '0;
            host.user[host_wr_pkg::uflag_fence] = 1'b1;
        end
    end

    // a beat is either an interrupt or a fence marker, never both
    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (rst_local)
        host.write |-> !(host.user[host_wr_pkg::uflag_interrupt] &&
                         host.user[host_wr_pkg::uflag_fence])
    );

endmodule

/* hdl/host_wr_top.sv */
/*
 host write subsystem top
 interrupt latches, selector, write DMA engine and write mux behind plain ports
*/
`timescale 1ns/10ps

module host_wr_top #(
    parameter int NUM_IRQ = 4
) (
    input  logic                            clk,
    input  logic                            rst_local,
    input  logic [NUM_IRQ-1:0]              bsp_irq,
    input  logic                            desc_valid,
    input  logic [host_wr_pkg::addr_w-1:0]  desc_addr,
    input  logic [host_wr_pkg::burst_w-1:0] desc_beats,
    input  logic                            desc_fence,
    input  logic [host_wr_pkg::data_w-1:0]  desc_magic,
    output logic                            desc_busy,
    output logic [host_wr_pkg::addr_w-1:0]  host_address,
    output logic [host_wr_pkg::data_w-1:0]  host_writedata,
    output logic [host_wr_pkg::be_w-1:0]    host_byteenable,
    output logic [host_wr_pkg::burst_w-1:0] host_burstcount,
    output logic                            host_write,
    output logic [host_wr_pkg::user_w-1:0]  host_user,
    input  logic                            host_waitrequest
);

    logic [NUM_IRQ-1:0] irq_pending;
    logic [NUM_IRQ-1:0] irq_clear;
    logic               irq_any;
    logic [1:0]         irq_id;
    logic               irq_sent;
    logic               fence_req;

    // engine to mux, and mux to the host pins
    host_wr_if dma_wr ();
    host_wr_if host_wr ();

    // one edge latch per board interrupt line
    for (genvar i = 0; i < NUM_IRQ; i++) begin : g_irq
        irq_line_latch irq_line_latch_i (
            .clk       (clk),
            .rst_local (rst_local),
            .irq       (bsp_irq[i]),
            .clear     (irq_clear[i]),
            .pending   (irq_pending[i])
        );
    end

    irq_select #(
        .NUM_IRQ (NUM_IRQ)
    ) irq_select_i (
        .clk       (clk),
        .rst_local (rst_local),
        .pending   (irq_pending),
        .irq_sent  (irq_sent),
        .irq_any   (irq_any),
        .irq_id    (irq_id),
        .clear     (irq_clear)
    );

    dma_wr_engine dma_wr_engine_i (
        .clk        (clk),
        .rst_local  (rst_local),
        .desc_valid (desc_valid),
        .desc_addr  (desc_addr),
        .desc_beats (desc_beats),
        .desc_fence (desc_fence),
        .desc_magic (desc_magic),
        .desc_busy  (desc_busy),
        .fence_req  (fence_req),
        .wr         (dma_wr.source)
    );

    host_wr_mux #(
        .NUM_IRQ (NUM_IRQ)
    ) host_wr_mux_i (
        .clk       (clk),
        .rst_local (rst_local),
        .dma       (dma_wr.sink),
        .host      (host_wr.source),
        .fence_req (fence_req),
        .irq_any   (irq_any),
        .irq_id    (irq_id),
        .irq_sent  (irq_sent)
    );

    // the host channel leaves the design as plain pins
    assign host_address        = host_wr.address;
    assign host_writedata      = host_wr.writedata;
    assign host_byteenable     = host_wr.byteenable;
    assign host_burstcount     = host_wr.burstcount;
    assign host_write          = host_wr.write;
    assign host_user           = host_wr.user;
    assign host_wr.waitrequest = host_waitrequest;

endmodule

/* verification/host_wr_tb.sv */
/*
 testbench for the host write subsystem
 random descriptors, interrupt pulses and host stalls checked by concurrent assertions
*/
`timescale 1ns/10ps

module host_wr_tb;

    localparam int num_irq    = 4;
    localparam int num_desc   = 40;
    localparam int max_beats  = 16;
    localparam int clk_period = 20;

    // where the current descriptor stands in its sequence of writes
    localparam logic [1:0] ph_burst = 2'd0;
    localparam logic [1:0] ph_fence = 2'd1;
    localparam logic [1:0] ph_magic = 2'd2;
    localparam logic [1:0] ph_done  = 2'd3;

    logic                            clk = 1'b0;
    logic                            rst_local = 1'b1;
    logic [num_irq-1:0]              bsp_irq = '0;
    logic                            desc_valid = 1'b0;
    logic [host_wr_pkg::addr_w-1:0]  desc_addr = '0;
    logic [host_wr_pkg::burst_w-1:0] desc_beats = '0;
    logic                            desc_fence = 1'b0;
    logic [host_wr_pkg::data_w-1:0]  desc_magic = '0;
    logic                            host_waitrequest = 1'b0;
    logic                            desc_busy;
    logic [host_wr_pkg::addr_w-1:0]  host_address;
    logic [host_wr_pkg::data_w-1:0]  host_writedata;
    logic [host_wr_pkg::be_w-1:0]    host_byteenable;
    logic [host_wr_pkg::burst_w-1:0] host_burstcount;
    logic                            host_write;
    logic [host_wr_pkg::user_w-1:0]  host_user;

    int   seed = 99177;
    logic irq_enable = 1'b0;

    // reference state, rebuilt from the beats seen on the host pins
    logic [num_irq-1:0]              pend_model;
    logic [num_irq-1:0]              irq_prev;
    int                              edge_cnt [num_irq];
    int                              sent_cnt [num_irq];
    logic [host_wr_pkg::burst_w-1:0] idx;
    logic [1:0]                      phase;
    logic                            after_fence;
    logic [host_wr_pkg::addr_w-1:0]  exp_addr;
    logic [host_wr_pkg::burst_w-1:0] exp_beats;
    logic                            exp_fence;
    logic [host_wr_pkg::data_w-1:0]  exp_magic;
    logic [host_wr_pkg::data_w-1:0]  exp_data;
    logic [host_wr_pkg::addr_w-1:0]  irq_expect;
    logic                            xfer;
    logic                            irq_xfer;
    logic                            fence_xfer;
    logic                            dma_xfer;

    host_wr_top #(
        .NUM_IRQ (num_irq)
    ) host_wr_top_i (
        .clk              (clk),
        .rst_local        (rst_local),
        .bsp_irq          (bsp_irq),
        .desc_valid       (desc_valid),
        .desc_addr        (desc_addr),
        .desc_beats       (desc_beats),
        .desc_fence       (desc_fence),
        .desc_magic       (desc_magic),
        .desc_busy        (desc_busy),
        .host_address     (host_address),
        .host_writedata   (host_writedata),
        .host_byteenable  (host_byteenable),
        .host_burstcount  (host_burstcount),
        .host_write       (host_write),
        .host_user        (host_user),
        .host_waitrequest (host_waitrequest)
    );

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    // the interrupt due next is the lowest line that is known to be pending
    // an empty set gives an id that no line can have
    function automatic logic [host_wr_pkg::addr_w-1:0] lowest_pending(
        input logic [num_irq-1:0] pend
    );
        logic [host_wr_pkg::addr_w-1:0] id;
        logic                           found;
        id    = '1;
        found = 1'b0;
        for (int i = 0; i < num_irq; i++) begin
            if (pend[i] && !found) begin
                id    = 32'(i);
                found = 1'b1;
            end
        end
        return id;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, want);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    assign xfer       = host_write && !host_waitrequest;
    assign irq_xfer   = xfer && host_user[host_wr_pkg::uflag_interrupt];
    assign fence_xfer = xfer && host_user[host_wr_pkg::uflag_fence];
    assign dma_xfer   = xfer && (host_user == '0);
    assign exp_data   = 64'(exp_addr) + 64'(idx);
    assign irq_expect = lowest_pending(pend_model);

    // an edge on a line is pending one cycle later and an interrupt write clears it
    // a set in the same cycle as the clear must win, so the set comes last
    always @(posedge clk) begin
        if (rst_local) begin
            pend_model  <= '0;
            irq_prev    <= '0;
            idx         <= '0;
            phase       <= ph_done;
            after_fence <= 1'b0;
            for (int i = 0; i < num_irq; i++) begin
                edge_cnt[i] <= 0;
                sent_cnt[i] <= 0;
            end
        end else begin
            irq_prev <= bsp_irq;
            if (irq_xfer) begin
                pend_model[host_address[1:0]] <= 1'b0;
                sent_cnt[host_address[1:0]]   <= sent_cnt[host_address[1:0]] + 1;
            end
            for (int i = 0; i < num_irq; i++) begin
                if (bsp_irq[i] && !irq_prev[i]) begin
                    pend_model[i] <= 1'b1;
                    edge_cnt[i]   <= edge_cnt[i] + 1;
                end
            end
            // strobes are only sent while the engine is idle, so each one starts a sequence
            if (desc_valid) begin
                exp_addr  <= desc_addr;
                exp_beats <= desc_beats;
                exp_fence <= desc_fence;
                exp_magic <= desc_magic;
                phase     <= ph_burst;
                idx       <= '0;
            end
            if (dma_xfer) begin
                if (phase == ph_burst) begin
                    idx <= idx + 8'd1;
                    if (idx + 8'd1 == exp_beats) begin
                        phase <= exp_fence ? ph_fence : ph_done;
                    end
                end else if (phase == ph_magic) begin
                    phase <= ph_done;
                end
            end
            if (fence_xfer && phase == ph_fence) begin
                phase <= ph_magic;
            end
            if (xfer) begin
                after_fence <= fence_xfer;
            end
        end
    end

    // host stalls on about a quarter of the cycles, one-cycle irq pulses on idle lines
    // a line is only pulsed again after its previous interrupt has gone out
    always @(posedge clk) begin
        host_waitrequest <= (($random(seed) & 3) == 0);
        for (int i = 0; i < num_irq; i++) begin
            if (bsp_irq[i]) begin
                bsp_irq[i] <= 1'b0;
            end else if (irq_enable && !pend_model[i] && (($random(seed) & 15) == 0)) begin
                bsp_irq[i] <= 1'b1;
            end
        end
    end

    a_irq_line: assert property (@(posedge clk) disable iff (rst_local)
        irq_xfer |-> host_address == irq_expect)
        else report_mismatch("host_address", 64'($sampled(host_address)),
                             64'($sampled(irq_expect)));
    a_irq_bcount: assert property (@(posedge clk) disable iff (rst_local)
        irq_xfer |-> host_burstcount == 8'd1)
        else report_mismatch("host_burstcount", 64'($sampled(host_burstcount)), 64'd1);
    a_irq_data: assert property (@(posedge clk) disable iff (rst_local)
        irq_xfer |-> host_writedata == '0)
        else report_mismatch("host_writedata", $sampled(host_writedata), 64'd0);
    a_irq_be: assert property (@(posedge clk) disable iff (rst_local)
        irq_xfer |-> host_byteenable == '1)
        else report_mismatch("host_byteenable", 64'($sampled(host_byteenable)), 64'hff);
    // a burst is open once its first beat has gone and until its last one has
    a_irq_outside_burst: assert property (@(posedge clk) disable iff (rst_local)
        irq_xfer |-> !(phase == ph_burst && idx != '0))
        else report_error("interrupt write sent in the middle of a DMA burst");

    a_dma_expected: assert property (@(posedge clk) disable iff (rst_local)
        dma_xfer |-> (phase == ph_burst || phase == ph_magic))
        else report_error("DMA write beat that no descriptor asked for");
    a_dma_addr: assert property (@(posedge clk) disable iff (rst_local)
        dma_xfer |-> host_address == exp_addr)
        else report_mismatch("host_address", 64'($sampled(host_address)),
                             64'($sampled(exp_addr)));
    a_dma_bcount: assert property (@(posedge clk) disable iff (rst_local)
        (dma_xfer && phase == ph_burst) |-> host_burstcount == exp_beats)
        else report_mismatch("host_burstcount", 64'($sampled(host_burstcount)),
                             64'($sampled(exp_beats)));
    a_dma_data: assert property (@(posedge clk) disable iff (rst_local)
        (dma_xfer && phase == ph_burst) |-> host_writedata == exp_data)
        else report_mismatch("host_writedata", $sampled(host_writedata), $sampled(exp_data));

    a_fence_expected: assert property (@(posedge clk) disable iff (rst_local)
        fence_xfer |-> phase == ph_fence)
        else report_error("fence marker on a descriptor that has no fence");
    a_fence_data: assert property (@(posedge clk) disable iff (rst_local)
        fence_xfer |-> host_writedata == exp_magic)
        else report_mismatch("host_writedata", $sampled(host_writedata), $sampled(exp_magic));
    a_magic_follows: assert property (@(posedge clk) disable iff (rst_local)
        (xfer && after_fence) |-> (dma_xfer && phase == ph_magic))
        else report_error("the write after a fence marker is not the magic write");
    a_magic_data: assert property (@(posedge clk) disable iff (rst_local)
        (dma_xfer && phase == ph_magic) |-> host_writedata == exp_magic)
        else report_mismatch("host_writedata", $sampled(host_writedata), $sampled(exp_magic));

    a_hold: assert property (@(posedge clk) disable iff (rst_local)
        (host_write && host_waitrequest) |=>
            (host_write && $stable(host_address) && $stable(host_writedata) &&
             $stable(host_byteenable) && $stable(host_burstcount) && $stable(host_user)))
        else report_error("host outputs changed while host_waitrequest was high");

    task automatic send_descriptor(input logic [31:0] addr, input logic [7:0] beats,
                                   input logic fence, input logic [63:0] magic);
        @(posedge clk);
        desc_valid <= 1'b1;
        desc_addr  <= addr;
        desc_beats <= beats;
        desc_fence <= fence;
        desc_magic <= magic;
        @(posedge clk);
        desc_valid <= 1'b0;
    endtask

    // busy rises after the strobe and falls once the last write has transferred
    task automatic wait_done();
        while (!desc_busy) @(posedge clk);
        while (desc_busy) @(posedge clk);
        if (phase != ph_done) begin
            report_error("descriptor finished with some of its writes missing");
        end
    endtask

    initial begin
        #(num_desc * max_beats * 8 * clk_period);
        report_error("timeout, the descriptors did not complete in time");
    end

    initial begin
        logic [31:0] addr;
        logic [7:0]  beats;
        logic        fence;
        logic [63:0] magic;
        int          bad_line;
        repeat (3) @(posedge clk);
        rst_local  <= 1'b0;
        irq_enable <= 1'b1;
        for (int d = 0; d < num_desc; d++) begin
            addr  = $random(seed);
            beats = 8'(1 + ($random(seed) & 15));
            fence = (($random(seed) & 1) == 1);
            magic = {$random(seed), $random(seed)};
            send_descriptor(addr, beats, fence, magic);
            wait_done();
        end
        // stop new pulses and let every pending line drain
        irq_enable <= 1'b0;
        repeat (2) @(posedge clk);
        while (pend_model != '0 || bsp_irq != '0) @(posedge clk);
        bad_line = -1;
        for (int i = 0; i < num_irq; i++) begin
            if (bad_line < 0 && sent_cnt[i] != edge_cnt[i]) begin
                bad_line = i;
            end
        end
        if (bad_line < 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            report_mismatch($sformatf("sent_cnt[%0d]", bad_line), 64'(sent_cnt[bad_line]),
                            64'(edge_cnt[bad_line]));
        end
    end

endmodule

/* host_wr_top.f */
hdl/host_wr_pkg.sv
hdl/host_wr_if.sv
hdl/irq_line_latch.sv
hdl/irq_select.sv
hdl/dma_wr_engine.sv
hdl/host_wr_mux.sv
hdl/host_wr_top.sv
verification/host_wr_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the simulation with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module host_wr_tb \
    -f host_wr_top.f -o host_wr_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/host_wr_sim > sim.log 2>&1
cat sim.log
# the run fails when the log holds the fail message or lacks the pass message
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0
